// ==== logic/opp_pkg.sv ====
package opp_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int w_in = 18;          // upstream error sample
	localparam int w_out = 16;         // downstream output sample
	localparam int w_gain = 8;         // front-panel gain

	localparam int comp_latency = 3;   // cycles held in st_compute

	//////////////////////////////
	// types
	//////////////////////////////

	typedef logic signed [w_in-1:0] in_data_t;      // sample from the mux
	typedef logic signed [w_out-1:0] out_data_t;    // output, bounds, init, prev
	typedef logic [w_gain-1:0] gain_t;              // unsigned gain
	typedef logic [7:0] cnt_t;                      // intrastate counter

	//////////////////////////////
	// limits
	//////////////////////////////

	// full-range bounds, also the reset bounds
	localparam out_data_t out_max = {1'b0, {(w_out-1){1'b1}}};   // most positive
	localparam out_data_t out_min = {1'b1, {(w_out-1){1'b0}}};   // most negative

	//////////////////////////////
	// sequencer
	//////////////////////////////

	typedef enum logic [1:0] {
		st_idle    = 2'd0,   // wait for a sample
		st_compute = 2'd1,   // datapath settling
		st_send    = 2'd2,   // result valid downstream
		st_done    = 2'd3    // commit result as previous
	} opp_state_t;

endpackage

// ==== logic/opp_param_bank.sv ====
`timescale 1ns/1ns

module opp_param_bank
	import opp_pkg::*;
(
	input  logic      clk_in,           // system clock
	input  logic      reset_in,         // sync reset, active high

	input  out_data_t output_max_in,    // front-panel upper bound
	input  out_data_t output_min_in,    // front-panel lower bound
	input  out_data_t output_init_in,   // front-panel initial value
	input  gain_t     multiplier_in,    // front-panel gain
	input  logic      update_en_in,     // arms the update pulse
	input  logic      update_in,        // update pulse

	output out_data_t output_max,       // active upper bound
	output out_data_t output_min,       // active lower bound
	output out_data_t output_init,      // active initial value
	output gain_t     multiplier,       // active gain
	output logic      param_load        // reload pulse for prev value
);

	//////////////////////////////
	// update qualification
	//////////////////////////////

	logic update_go;   // enabled update at this edge

	assign update_go = update_in & update_en_in;

	//////////////////////////////
	// shadow registers
	//////////////////////////////

	// values only move on an enabled update, so edits in progress stay out
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			output_max  <= out_max;        // full range
			output_min  <= out_min;
			output_init <= '0;
			multiplier  <= gain_t'(1);     // unity gain
		end else if (update_go) begin
			output_max  <= output_max_in;
			output_min  <= output_min_in;
			output_init <= output_init_in;
			multiplier  <= multiplier_in;
		end
	end

	// one edge behind the load, so output_init is already the new value
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			param_load <= 1'b0;
		end else begin
			param_load <= update_go;       // enable already folded in
		end
	end

endmodule

// ==== logic/opp_control.sv ====
`timescale 1ns/1ns

module opp_control
	import opp_pkg::*;
(
	input  logic clk_in,           // system clock
	input  logic reset_in,         // sync reset, active high
	input  logic data_valid_in,    // sample strobe from the mux

	output logic capture,          // sample accepted this cycle
	output logic commit,           // store result as previous
	output logic data_valid_out    // result valid downstream
);

	//////////////////////////////
	// state
	//////////////////////////////

	opp_state_t state;        // current state
	opp_state_t next_state;   // next state
	cnt_t       counter;      // cycles spent in current state

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	// counter restarts on every transition
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			counter <= '0;
		end else if (state != next_state) begin
			counter <= '0;
		end else begin
			counter <= counter + 1'b1;    // free-running while idle, wraps
		end
	end

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		next_state = state;   // hold by default
		case (state)
			st_idle: begin
				if (data_valid_in) begin
					next_state = st_compute;
				end
			end
			st_compute: begin
				// leave after comp_latency cycles
				if (counter == cnt_t'(comp_latency - 1)) begin
					next_state = st_send;
				end
			end
			st_send: begin
				next_state = st_done;     // single-cycle valid pulse
			end
			st_done: begin
				next_state = st_idle;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	//////////////////////////////
	// strobes
	//////////////////////////////

	assign capture        = (state == st_idle) && data_valid_in;   // busy strobes dropped
	assign data_valid_out = (state == st_send);
	assign commit         = (state == st_done);

endmodule

// ==== logic/opp_scaler.sv ====
`timescale 1ns/1ns

module opp_scaler
	import opp_pkg::*;
(
	input  logic      clk_in,       // system clock
	input  logic      reset_in,     // sync reset, active high
	input  in_data_t  data_in,      // upstream error sample
	input  logic      capture,      // accept strobe from sequencer
	input  gain_t     multiplier,   // active gain

	output out_data_t scaled        // saturated, gain-scaled sample
);

	//////////////////////////////
	// capture
	//////////////////////////////

	out_data_t lock_data;   // sample reduced to output width

	// keep the top bits and drop the lsbs
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			lock_data <= '0;
		end else if (capture) begin
			lock_data <= data_in[w_in-1 -: w_out];
		end
	end

	//////////////////////////////
	// gain multiply
	//////////////////////////////

	logic signed [w_out+w_gain:0] product;   // full signed product
	out_data_t                    product_sat;

	// gain is unsigned, zero-extend before the signed multiply
	assign product = lock_data * $signed({1'b0, multiplier});

	always_comb begin
		if (product > out_max) begin
			product_sat = out_max;                  // positive overflow
		end else if (product < out_min) begin
			product_sat = out_min;                  // negative overflow
		end else begin
			product_sat = product[w_out-1:0];
		end
	end

	// one cycle after capture
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			scaled <= '0;
		end else begin
			scaled <= product_sat;
		end
	end

endmodule

// ==== logic/opp_accumulator.sv ====
`timescale 1ns/1ns

module opp_accumulator
	import opp_pkg::*;
(
	input  logic      clk_in,        // system clock
	input  logic      reset_in,      // sync reset, active high
	input  out_data_t scaled,        // scaled sample from scaler
	input  logic      lock_en_in,    // lock on, else preset output
	input  out_data_t output_init,   // active initial value
	input  out_data_t output_max,    // active upper bound
	input  out_data_t output_min,    // active lower bound
	input  logic      commit,        // store result as previous
	input  logic      param_load,    // reload previous with init

	output out_data_t data_out       // clamped result
);

	//////////////////////////////
	// previous output
	//////////////////////////////

	out_data_t data_out_prev;   // last value sent downstream

	// param_load takes priority over commit
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_out_prev <= '0;
		end else if (param_load) begin
			data_out_prev <= output_init;
		end else if (commit) begin
			data_out_prev <= data_out;
		end
	end

	//////////////////////////////
	// saturating add
	//////////////////////////////

	logic signed [w_out:0] sum_wide;   // one guard bit
	out_data_t             sum_sat;

	assign sum_wide = {scaled[w_out-1], scaled} + {data_out_prev[w_out-1], data_out_prev};

	// guard and sign bit disagree on overflow
	always_comb begin
		if (sum_wide[w_out] != sum_wide[w_out-1]) begin
			sum_sat = sum_wide[w_out] ? out_min : out_max;   // guard bit gives direction
		end else begin
			sum_sat = sum_wide[w_out-1:0];
		end
	end

	//////////////////////////////
	// lock select and clamp
	//////////////////////////////

	out_data_t locked;       // sum or preset
	out_data_t upper_cut;    // after upper bound

	assign locked = lock_en_in ? sum_sat : output_init;

	// upper bound first, then lower
	always_comb begin
		if (locked > output_max) begin
			upper_cut = output_max;
		end else begin
			upper_cut = locked;
		end
	end

	always_comb begin
		if (upper_cut < output_min) begin
			data_out = output_min;   // lower bound wins on crossed bounds
		end else begin
			data_out = upper_cut;
		end
	end

endmodule

// ==== logic/opp_top.sv ====
`timescale 1ns/1ns

module opp_top
	import opp_pkg::*;
(
	input  logic      clk_in,           // system clock
	input  logic      reset_in,         // sync reset, active high

	input  in_data_t  data_in,          // error sample from mux
	input  logic      data_valid_in,    // one-cycle sample strobe

	input  out_data_t output_max_in,    // front-panel upper bound
	input  out_data_t output_min_in,    // front-panel lower bound
	input  out_data_t output_init_in,   // front-panel initial value
	input  gain_t     multiplier_in,    // front-panel gain
	input  logic      lock_en_in,       // lock enable level
	input  logic      update_en_in,     // update enable level
	input  logic      update_in,        // update pulse

	output out_data_t data_out,         // output sample
	output logic      data_valid_out    // output valid pulse
);

	//////////////////////////////
	// internal wires
	//////////////////////////////

	out_data_t output_max;    // active settings
	out_data_t output_min;
	out_data_t output_init;
	gain_t     multiplier;
	logic      param_load;    // prev reload pulse
	logic      capture;       // sample accepted
	logic      commit;        // result committed
	out_data_t scaled;        // scaler to accumulator

	//////////////////////////////
	// blocks
	//////////////////////////////

	opp_param_bank opp_param_bank_i (
		.clk_in, .reset_in,
		.output_max_in, .output_min_in, .output_init_in, .multiplier_in,
		.update_en_in, .update_in,
		.output_max, .output_min, .output_init, .multiplier, .param_load
	);

	opp_control opp_control_i (
		.clk_in, .reset_in, .data_valid_in,
		.capture, .commit, .data_valid_out
	);

	opp_scaler opp_scaler_i (
		.clk_in, .reset_in, .data_in, .capture, .multiplier,
		.scaled
	);

	opp_accumulator opp_accumulator_i (
		.clk_in, .reset_in, .scaled, .lock_en_in,
		.output_init, .output_max, .output_min, .commit, .param_load,
		.data_out
	);

endmodule

// ==== verification/opp_asserts.sv ====
`timescale 1ns/1ns

module opp_asserts
	import opp_pkg::*;
(
	input logic clk_in,           // system clock
	input logic reset_in,         // sync reset, active high
	input logic data_valid_in,    // sample strobe
	input logic data_valid_out    // result pulse
);

	//////////////////////////////
	// acceptance tracking
	//////////////////////////////

	logic [3:0] busy_cnt;         // edges left before idle again
	logic       accept;           // strobe taken while idle
	int         fail_count = 0;   // assertion failures seen

	assign accept = data_valid_in && (busy_cnt == 4'd0);

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			busy_cnt <= '0;
		end else if (busy_cnt != 4'd0) begin
			busy_cnt <= busy_cnt - 4'd1;
		end else if (data_valid_in) begin
			busy_cnt <= 4'(comp_latency + 2);   // compute, send, done
		end
	end

	a_single_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out) else begin
		$error("data_valid_out high twice in a row");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk_in)
		reset_in && $past(reset_in) |-> !data_valid_out) else begin
		$error("valid during reset");
		fail_count++;
	end

	a_latency: assert property (@(posedge clk_in) disable iff (reset_in)
		accept |-> ##(comp_latency + 1) data_valid_out) else begin
		$error("valid pulse late");
		fail_count++;
	end

endmodule

// ==== verification/opp_tb.sv ====
`timescale 1ns/1ns

module opp_tb
	import opp_pkg::*;
();

	//////////////////////////////
	// dut signals
	//////////////////////////////

	logic      clk_in;
	logic      reset_in;
	in_data_t  data_in;
	logic      data_valid_in;
	out_data_t output_max_in;
	out_data_t output_min_in;
	out_data_t output_init_in;
	gain_t     multiplier_in;
	logic      lock_en_in;
	logic      update_en_in;
	logic      update_in;
	out_data_t data_out;
	logic      data_valid_out;

	localparam int n_txn = 269;                      // transactions over all tests
	localparam int cycle_limit = 40 * n_txn + 100;   // run budget

	opp_top opp_top_i (.*);

	bind opp_top opp_asserts opp_asserts_i (
		.clk_in, .reset_in, .data_valid_in, .data_valid_out
	);

	always #5 clk_in = ~clk_in;   // 10 ns period

	//////////////////////////////
	// model state
	//////////////////////////////

	out_data_t   m_max, m_min, m_init, m_prev;   // model copy of settings and history
	gain_t       m_gain;
	logic        m_lock;
	out_data_t   exp_q[$];                       // expected results in order
	out_data_t   last_data;                      // last value seen with valid
	logic [31:0] lfsr_state;
	string       test_name;
	int          checks, errors, test_checks0, test_errors0;
	int          cyc, acc_edge, next_free, accepted_count;
	int          rx_count, tx_count, timeout_cycles;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h80200003;   // taps 32 22 2 1
		end
		return n;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		int          i;
		bits = '0;
		for (i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return bits;
	endfunction

	function automatic in_data_t rand_sample();
		logic [31:0] raw;
		int          shift;
		raw = rand_bits(18);
		shift = int'(rand_bits(4));   // spread magnitudes
		return in_data_t'($signed(raw[17:0]) >>> shift);
	endfunction

	function automatic int sat_int(input int v);
		if (v > int'(out_max)) begin
			return int'(out_max);
		end else if (v < int'(out_min)) begin
			return int'(out_min);
		end
		return v;
	endfunction

	function automatic out_data_t ref_output(input in_data_t sample, input gain_t gain,
		input out_data_t prev, input logic lock, input out_data_t init,
		input out_data_t hi, input out_data_t lo);
		int top;
		int val;
		top = int'(sample) >>> (w_in - w_out);   // drop lsbs
		val = sat_int(top * int'(gain));         // saturating gain
		val = sat_int(val + int'(prev));         // saturating accumulate
		if (!lock) begin
			val = int'(init);                    // preset when unlocked
		end
		if (val > int'(hi)) begin
			val = int'(hi);                      // upper first
		end
		if (val < int'(lo)) begin
			val = int'(lo);
		end
		return out_data_t'(val);
	endfunction

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_data(input string name, input out_data_t exp, input out_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s data: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s latency: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// watches every edge and tracks idle acceptance on its own
	always @(posedge clk_in) begin
		cyc = cyc + 1;
		if (!reset_in) begin
			if (data_valid_out) begin
				rx_count++;
				last_data = data_out;
				check_count(test_name, cnt_t'(comp_latency + 1), cnt_t'(cyc - acc_edge));
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected data_valid_out pulse in test %s", test_name);
				end else begin
					check_data(test_name, exp_q.pop_front(), data_out);
				end
			end
			if (data_valid_in && cyc >= next_free) begin
				accepted_count++;
				acc_edge = cyc;
				next_free = cyc + comp_latency + 3;   // earliest next acceptance
			end
		end
	end

	always @(posedge clk_in) begin
		timeout_cycles++;
		if (timeout_cycles >= cycle_limit) begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////

	task automatic start_test(input string name);
		test_name = name;
		test_checks0 = checks;
		test_errors0 = errors;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", test_name,
			checks - test_checks0, errors - test_errors0);
	endtask

	task automatic wait_result();
		int waited;
		waited = 0;
		while (rx_count < tx_count && waited < 20) begin
			@(negedge clk_in);
			waited++;
		end
		if (rx_count < tx_count) begin
			errors++;
			$display("no data_valid_out pulse arrived in test %s", test_name);
			exp_q.delete();   // resync the queue
		end
	endtask

	task automatic set_lock(input logic en);
		@(negedge clk_in);
		lock_en_in = en;
		m_lock = en;
	endtask

	task automatic apply_update(input out_data_t hi, input out_data_t lo, input out_data_t init,
		input gain_t gain, input logic en);
		@(negedge clk_in);
		output_max_in = hi;
		output_min_in = lo;
		output_init_in = init;
		multiplier_in = gain;
		update_en_in = en;
		update_in = 1'b1;
		@(negedge clk_in);
		update_in = 1'b0;
		update_en_in = 1'b0;
		if (en) begin
			m_max = hi;
			m_min = lo;
			m_init = init;
			m_gain = gain;
			m_prev = init;   // history reload
		end
	endtask

	// busy_edges extra edges with the strobe held high
	task automatic drive_sample(input in_data_t sample, input int busy_edges);
		out_data_t exp;
		exp = ref_output(sample, m_gain, m_prev, m_lock, m_init, m_max, m_min);
		m_prev = exp;
		exp_q.push_back(exp);
		tx_count++;
		@(negedge clk_in);
		data_in = sample;
		data_valid_in = 1'b1;
		repeat (busy_edges) begin
			@(negedge clk_in);
			data_in = rand_sample();   // ignored by the dut
		end
		@(negedge clk_in);
		data_valid_in = 1'b0;
		wait_result();
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		int blk;
		clk_in = 1'b0;
		reset_in = 1'b1;
		data_in = '0;
		data_valid_in = 1'b0;
		output_max_in = out_max;
		output_min_in = out_min;
		output_init_in = '0;
		multiplier_in = gain_t'(1);
		lock_en_in = 1'b0;
		update_en_in = 1'b0;
		update_in = 1'b0;
		m_max = out_max;   // reset defaults
		m_min = out_min;
		m_init = '0;
		m_prev = '0;
		m_gain = gain_t'(1);
		m_lock = 1'b0;
		lfsr_state = 32'hdc57441f;
		checks = 0;
		errors = 0;
		cyc = 0;
		acc_edge = 0;
		next_free = 0;
		accepted_count = 0;
		rx_count = 0;
		tx_count = 0;
		timeout_cycles = 0;
		last_data = '0;

		start_test("reset_defaults");
		repeat (5) begin
			@(negedge clk_in);
			checks++;
			if (data_valid_out !== 1'b0) begin
				errors++;
				$display("data_valid_out was not low during reset");
			end
		end
		reset_in = 1'b0;
		set_lock(1'b1);
		drive_sample(18'sd400, 0);
		drive_sample(-18'sd1000, 0);
		drive_sample(18'sd131071, 0);
		end_test();

		start_test("random_gain");
		for (blk = 0; blk < 4; blk++) begin
			apply_update(out_max, out_min, out_data_t'(rand_bits(16)),
				gain_t'(rand_bits(8)), 1'b1);
			repeat (50) drive_sample(rand_sample(), 0);
		end
		end_test();

		start_test("saturation");
		apply_update(out_max, out_min, '0, gain_t'(255), 1'b1);
		repeat (5) drive_sample(18'sh1ffff, 0);   // product and sum at max
		check_data("saturation_max_hold", out_max, last_data);
		repeat (5) drive_sample(18'sh20000, 0);
		check_data("saturation_min_hold", out_min, last_data);
		apply_update(out_max, out_min, '0, gain_t'(2), 1'b1);
		repeat (6) drive_sample(18'sd40000, 0);   // sum only saturates
		check_data("sum_max_hold", out_max, last_data);
		repeat (6) drive_sample(-18'sd40000, 0);
		check_data("sum_min_hold", out_min, last_data);
		end_test();

		start_test("bounds");
		apply_update(out_data_t'(500), out_data_t'(-300), '0, gain_t'(3), 1'b1);
		repeat (30) begin
			drive_sample(rand_sample(), 0);
			checks++;
			if (last_data > m_max || last_data < m_min) begin
				errors++;
				$display("result %0d outside the bounds in test %s", last_data, test_name);
			end
		end
		apply_update(out_data_t'(-100), out_data_t'(100), '0, gain_t'(3), 1'b1);   // crossed
		repeat (3) drive_sample(rand_sample(), 0);
		check_data("crossed_bounds", out_data_t'(100), last_data);
		end_test();

		start_test("lock_update");
		set_lock(1'b0);
		apply_update(out_data_t'(1000), out_data_t'(-1000), out_data_t'(1234), gain_t'(1), 1'b1);
		repeat (3) drive_sample(rand_sample(), 0);
		check_data("unlocked_clamp", out_data_t'(1000), last_data);
		apply_update(out_data_t'(1000), out_data_t'(-1000), out_data_t'(-50), gain_t'(1), 1'b1);
		repeat (2) drive_sample(rand_sample(), 0);
		set_lock(1'b1);
		apply_update(out_max, out_min, out_data_t'(700), gain_t'(1), 1'b1);
		drive_sample(18'sd0, 0);
		check_data("update_reload", out_data_t'(700), last_data);
		apply_update(out_data_t'(100), out_data_t'(-100), out_data_t'(-5000), gain_t'(200), 1'b0);
		drive_sample(18'sd400, 0);   // 100 on top of 700
		check_data("update_disabled", out_data_t'(800), last_data);
		end_test();

		start_test("busy_ignored");
		repeat (4) drive_sample(rand_sample(), comp_latency + 2);
		checks++;
		if (accepted_count != rx_count || rx_count != tx_count) begin
			errors++;
			$display("pulse count %0d does not match %0d accepted strobes", rx_count,
				accepted_count);
		end
		end_test();

		repeat (3) @(negedge clk_in);
		errors = errors + opp_top_i.opp_asserts_i.fail_count;   // bound checker failures
		$display("checks %0d, errors %0d, pulses %0d, cycles %0d", checks, errors, rx_count, cyc);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
logic/opp_pkg.sv
logic/opp_param_bank.sv
logic/opp_control.sv
logic/opp_scaler.sv
logic/opp_accumulator.sv
logic/opp_top.sv
verification/opp_asserts.sv
verification/opp_tb.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat sources.f))

.PHONY: all run clean

all: run

obj_dir/Vopp_tb: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module opp_tb -f sources.f -o Vopp_tb

run: obj_dir/Vopp_tb
	./obj_dir/Vopp_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
